// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fifo_sync_axil
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/fifo_axil_regs.sv ====
`timescale 1ns/10ps

module fifo_axil_regs #(
    parameter int DEPTH = 32
) (
    input  logic                   clk,
    input  logic                   rst,

    // Write address and data
    input  logic                   axil_awvalid,
    output logic                   axil_awready,
    input  fifo_pkg::axil_addr_t   axil_awaddr,
    input  logic                   axil_wvalid,
    output logic                   axil_wready,
    input  fifo_pkg::axil_data_t   axil_wdata,
    input  logic [3:0]             axil_wstrb,

    // Write response
    output logic                   axil_bvalid,
    input  logic                   axil_bready,
    output logic [1:0]             axil_bresp,

    // Read address and data
    input  logic                   axil_arvalid,
    output logic                   axil_arready,
    input  fifo_pkg::axil_addr_t   axil_araddr,
    output logic                   axil_rvalid,
    input  logic                   axil_rready,
    output fifo_pkg::axil_data_t   axil_rdata,
    output logic [1:0]             axil_rresp,

    // Buffer status in, flush out
    input  logic                   full,
    input  logic                   empty,
    input  fifo_pkg::count_t       wr_count,
    input  logic                   oflow,
    input  logic                   uflow,
    output logic                   flush
);

    import fifo_pkg::*;

    axil_state_t state;
    logic        wr_go;
    logic        rd_go;
    logic        ctrl_wr;
    logic        clear_req;
    logic        sticky_oflow;
    logic        sticky_uflow;
    axil_data_t  rd_word;

    // ------------------------------
    // Handshakes
    // ------------------------------
    // Writes win when both kinds arrive together
    assign wr_go = (state == AXIL_IDLE) && axil_awvalid && axil_wvalid;
    assign rd_go = (state == AXIL_IDLE) && axil_arvalid && !(axil_awvalid && axil_wvalid);

    assign axil_awready = wr_go;
    assign axil_wready  = wr_go;
    assign axil_arready = rd_go;
    assign axil_bvalid  = (state == AXIL_WRESP);
    assign axil_rvalid  = (state == AXIL_RDATA);
    assign axil_bresp   = AXIL_RESP_OKAY;
    assign axil_rresp   = AXIL_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= AXIL_IDLE;
        end else begin
            case (state)
                AXIL_IDLE: begin
                    if (wr_go) begin
                        state <= AXIL_WRESP;
                    end else if (rd_go) begin
                        state <= AXIL_RDATA;
                    end
                end
                AXIL_WRESP: if (axil_bready) state <= AXIL_IDLE;
                AXIL_RDATA: if (axil_rready) state <= AXIL_IDLE;
                default:    state <= AXIL_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Control register
    // ------------------------------
    assign ctrl_wr   = wr_go && (axil_awaddr == REG_CONTROL) && axil_wstrb[0];
    assign clear_req = ctrl_wr && axil_wdata[CTRL_CLEAR_BIT];

    // Flush pulse lines up with the write response
    always_ff @(posedge clk) begin
        if (rst) begin
            flush        <= 1'b0;
            sticky_oflow <= 1'b0;
            sticky_uflow <= 1'b0;
        end else begin
            flush        <= ctrl_wr && axil_wdata[CTRL_FLUSH_BIT];
            // A new event beats a clear in the same cycle
            sticky_oflow <= oflow || (sticky_oflow && !clear_req);
            sticky_uflow <= uflow || (sticky_uflow && !clear_req);
        end
    end

    // ------------------------------
    // Read mux
    // ------------------------------
    always_comb begin
        rd_word = '0;
        case (axil_araddr)
            REG_STATUS: begin
                rd_word[STATUS_EMPTY_BIT] = empty;
                rd_word[STATUS_FULL_BIT]  = full;
                rd_word[STATUS_OFLOW_BIT] = sticky_oflow;
                rd_word[STATUS_UFLOW_BIT] = sticky_uflow;
            end
            REG_COUNT: rd_word = axil_data_t'(wr_count);
            REG_DEPTH: rd_word = axil_data_t'(DEPTH);
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            axil_rdata <= rd_word;
        end
    end

    a_one_response : assert property (
        @(posedge clk) disable iff (rst)
        !(axil_bvalid && axil_rvalid)
    );

endmodule : fifo_axil_regs

// ==== hdl/fifo_mem.sv ====
`timescale 1ns/10ps

module fifo_mem #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,

    // Write port
    input  logic                     mem_we,
    input  logic [$clog2(DEPTH)-1:0] mem_waddr,
    input  fifo_pkg::data_t          mem_wdata,

    // Read port with data one cycle after mem_re
    input  logic                     mem_re,
    input  logic [$clog2(DEPTH)-1:0] mem_raddr,
    output fifo_pkg::data_t          mem_rdata
);

    import fifo_pkg::*;

    // Plain array so it maps onto block RAM
    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Output register holds its word until the next read
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem[mem_raddr];
        end
    end

endmodule : fifo_mem

// ==== hdl/fifo_pkg.sv ====
package fifo_pkg;

    // ------------------------------
    // Data path types
    // ------------------------------
    typedef logic [15:0] data_t;
    typedef logic [15:0] count_t;

    // ------------------------------
    // Register interface
    // ------------------------------
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // Register byte offsets
    localparam axil_addr_t REG_STATUS  = 8'h00;
    localparam axil_addr_t REG_COUNT   = 8'h04;
    localparam axil_addr_t REG_DEPTH   = 8'h08;
    localparam axil_addr_t REG_CONTROL = 8'h0C;

    // STATUS layout
    localparam int STATUS_EMPTY_BIT  = 0;
    localparam int STATUS_FULL_BIT   = 1;
    localparam int STATUS_OFLOW_BIT  = 2;
    localparam int STATUS_UFLOW_BIT  = 3;

    // CONTROL layout
    localparam int CTRL_FLUSH_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // One transaction in flight at a time
    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_WRESP,
        AXIL_RDATA
    } axil_state_t;

endpackage : fifo_pkg

// ==== hdl/fifo_rd_ctrl.sv ====
`timescale 1ns/10ps

module fifo_rd_ctrl #(
    parameter int DEPTH      = 32,
    parameter bit FWFT       = 1,
    parameter bit UFLOW_PROT = 1
) (
    input  logic                     clk,
    input  logic                     rst,

    // Outside read port
    input  logic                     rd,
    output logic                     rd_ack,
    output fifo_pkg::data_t          rd_data,
    output fifo_pkg::count_t         rd_count,
    output logic                     empty,
    output logic                     uflow,

    // Pointer exchange with the write side
    input  logic [$clog2(DEPTH):0]   wr_ptr,
    output logic [$clog2(DEPTH):0]   rd_ptr,
    input  logic                     flush,

    // Storage read port
    output logic                     mem_re,
    output logic [$clog2(DEPTH)-1:0] mem_raddr,
    input  fifo_pkg::data_t          mem_rdata
);

    import fifo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    logic [PTR_W-1:0] fetch_ptr;
    logic [PTR_W-1:0] fetch_level;
    logic [PTR_W-1:0] wr_ptr_d;
    logic [PTR_W-1:0] rd_level;
    logic             out_valid;
    logic             pop;

    // Words written but not yet fetched from storage
    assign fetch_level = wr_ptr - fetch_ptr;
    assign mem_raddr   = fetch_ptr[ADDR_W-1:0];

    // ------------------------------
    // Fetch and pop decisions
    // ------------------------------
    always_comb begin
        if (FWFT) begin
            // Head word waits in the storage output register
            empty  = !out_valid;
            pop    = rd && out_valid;
            mem_re = !flush && (fetch_level != '0) && (!out_valid || pop);
        end else begin
            empty  = (wr_ptr == rd_ptr);
            pop    = rd && (!empty || !UFLOW_PROT) && !flush;
            mem_re = pop;
        end
    end

    assign rd_ack  = FWFT ? pop : out_valid;
    assign rd_data = mem_rdata;

    // Words the read side can hand out
    assign rd_level = (FWFT ? wr_ptr_d : wr_ptr) - rd_ptr;
    assign rd_count = count_t'(rd_level);

    // ------------------------------
    // Pointers and output valid
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fetch_ptr <= '0;
            rd_ptr    <= '0;
            wr_ptr_d  <= '0;
            out_valid <= 1'b0;
        end else begin
            wr_ptr_d <= wr_ptr;
            if (mem_re) begin
                fetch_ptr <= fetch_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (!FWFT) begin
                // Standard mode acks the cycle after the storage read
                out_valid <= mem_re;
            end else if (mem_re) begin
                out_valid <= 1'b1;
            end else if (pop) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uflow <= 1'b0;
        end else begin
            uflow <= rd && empty;
        end
    end

    // No ack for a read that found the buffer empty
    a_no_ack_when_empty : assert property (
        @(posedge clk) disable iff (rst || (!FWFT && !UFLOW_PROT))
        rd_ack |-> (FWFT ? (rd_count != '0) : !$past(empty))
    );

    // Fetch pointer stays behind the write pointer
    a_fetch_behind_wr : assert property (
        @(posedge clk) disable iff (rst)
        fetch_level <= PTR_W'(DEPTH)
    );

endmodule : fifo_rd_ctrl

// ==== hdl/fifo_sync_axil.sv ====
`timescale 1ns/10ps

module fifo_sync_axil #(
    parameter int DEPTH      = 32,
    parameter bit FWFT       = 1,
    parameter bit OFLOW_PROT = 1,
    parameter bit UFLOW_PROT = 1
) (
    input  logic                 clk,
    input  logic                 rst,

    // Write port
    output logic                 wr_rdy,
    input  logic                 wr,
    input  fifo_pkg::data_t      wr_data,
    output fifo_pkg::count_t     wr_count,
    output logic                 full,
    output logic                 oflow,

    // Read port
    input  logic                 rd,
    output logic                 rd_ack,
    output fifo_pkg::data_t      rd_data,
    output fifo_pkg::count_t     rd_count,
    output logic                 empty,
    output logic                 uflow,

    // AXI4-Lite control and monitoring
    input  logic                 axil_awvalid,
    output logic                 axil_awready,
    input  fifo_pkg::axil_addr_t axil_awaddr,
    input  logic                 axil_wvalid,
    output logic                 axil_wready,
    input  fifo_pkg::axil_data_t axil_wdata,
    input  logic [3:0]           axil_wstrb,
    output logic                 axil_bvalid,
    input  logic                 axil_bready,
    output logic [1:0]           axil_bresp,
    input  logic                 axil_arvalid,
    output logic                 axil_arready,
    input  fifo_pkg::axil_addr_t axil_araddr,
    output logic                 axil_rvalid,
    input  logic                 axil_rready,
    output fifo_pkg::axil_data_t axil_rdata,
    output logic [1:0]           axil_rresp
);

    import fifo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              flush;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_waddr;
    data_t             mem_wdata;
    logic              mem_re;
    logic [ADDR_W-1:0] mem_raddr;
    data_t             mem_rdata;

    // ------------------------------
    // Write side
    // ------------------------------
    fifo_wr_ctrl #(
        .DEPTH      (DEPTH),
        .OFLOW_PROT (OFLOW_PROT)
    ) u_wr_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .full      (full),
        .oflow     (oflow),
        .wr_count  (wr_count),
        .rd_ptr    (rd_ptr),
        .wr_ptr    (wr_ptr),
        .flush     (flush),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    // Storage
    fifo_mem #(
        .DEPTH (DEPTH)
    ) u_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    // ------------------------------
    // Read side
    // ------------------------------
    fifo_rd_ctrl #(
        .DEPTH      (DEPTH),
        .FWFT       (FWFT),
        .UFLOW_PROT (UFLOW_PROT)
    ) u_rd_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .rd_count  (rd_count),
        .empty     (empty),
        .uflow     (uflow),
        .wr_ptr    (wr_ptr),
        .rd_ptr    (rd_ptr),
        .flush     (flush),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    // Register block
    fifo_axil_regs #(
        .DEPTH (DEPTH)
    ) u_regs (
        .clk          (clk),
        .rst          (rst),
        .axil_awvalid (axil_awvalid),
        .axil_awready (axil_awready),
        .axil_awaddr  (axil_awaddr),
        .axil_wvalid  (axil_wvalid),
        .axil_wready  (axil_wready),
        .axil_wdata   (axil_wdata),
        .axil_wstrb   (axil_wstrb),
        .axil_bvalid  (axil_bvalid),
        .axil_bready  (axil_bready),
        .axil_bresp   (axil_bresp),
        .axil_arvalid (axil_arvalid),
        .axil_arready (axil_arready),
        .axil_araddr  (axil_araddr),
        .axil_rvalid  (axil_rvalid),
        .axil_rready  (axil_rready),
        .axil_rdata   (axil_rdata),
        .axil_rresp   (axil_rresp),
        .full         (full),
        .empty        (empty),
        .wr_count     (wr_count),
        .oflow        (oflow),
        .uflow        (uflow),
        .flush        (flush)
    );

    // Counts up to DEPTH plus the two fall-through words must fit,
    // and pointer wrap needs a power-of-two depth
    a_count_width : assert property (
        @(posedge clk) disable iff (rst)
        ($bits(count_t) >= $clog2(DEPTH + 3)) && (DEPTH == (1 << ADDR_W))
    );

endmodule : fifo_sync_axil

// ==== hdl/fifo_wr_ctrl.sv ====
`timescale 1ns/10ps

module fifo_wr_ctrl #(
    parameter int DEPTH      = 32,
    parameter bit OFLOW_PROT = 1
) (
    input  logic                    clk,
    input  logic                    rst,

    // Outside write port
    input  logic                    wr,
    input  fifo_pkg::data_t         wr_data,
    output logic                    wr_rdy,
    output logic                    full,
    output logic                    oflow,
    output fifo_pkg::count_t        wr_count,

    // Pointer exchange with the read side
    input  logic [$clog2(DEPTH):0]  rd_ptr,
    output logic [$clog2(DEPTH):0]  wr_ptr,
    input  logic                    flush,

    // Storage write port
    output logic                    mem_we,
    output logic [$clog2(DEPTH)-1:0] mem_waddr,
    output fifo_pkg::data_t         mem_wdata
);

    import fifo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    logic             rdy_en;
    logic [PTR_W-1:0] level;

    // ------------------------------
    // Fill level and flags
    // ------------------------------
    // Extra pointer bit tells a full buffer from an empty one
    assign level    = wr_ptr - rd_ptr;
    assign full     = (level >= PTR_W'(DEPTH));
    assign wr_count = count_t'(level);

    // Held low for the first cycle out of reset
    assign wr_rdy = rdy_en && (!full || !OFLOW_PROT);

    // Without protection a write to a full buffer still lands
    assign mem_we    = wr && wr_rdy && !flush;
    assign mem_waddr = wr_ptr[ADDR_W-1:0];
    assign mem_wdata = wr_data;

    // ------------------------------
    // Pointer and overflow flag
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_en <= 1'b0;
            oflow  <= 1'b0;
            wr_ptr <= '0;
        end else begin
            rdy_en <= 1'b1;
            // One-cycle flag after any write attempt while full
            oflow  <= wr && full;
            if (flush) begin
                wr_ptr <= '0;
            end else if (mem_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Fill level stays within the storage when protected
    a_wr_count_max : assert property (
        @(posedge clk) disable iff (rst || !OFLOW_PROT)
        wr_count <= count_t'(DEPTH)
    );

endmodule : fifo_wr_ctrl

// ==== tb.f ====
hdl/fifo_pkg.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_mem.sv
hdl/fifo_rd_ctrl.sv
hdl/fifo_axil_regs.sv
hdl/fifo_sync_axil.sv
tb/tb_fifo_sync_axil.sv

// ==== tb/fifo_trace.txt ====
# op and args: T name | W word | WS first n | R word | RS first n | U | I cycles
# RW addr data | RR addr data | F flag bit | C count   (words, addr, data, count in hex)
T order
F empty 1
F full 0
F wr_rdy 1
W 1111
W 2222
W 3333
W a5a5
R 1111
R 2222
R 3333
R a5a5
F empty 1
T fill
WS 0100 32
F full 1
F wr_rdy 0
W 0bad
F oflow 1
F oflow 0
RS 0100 32
F empty 1
T underflow
U
F uflow 1
F uflow 0
RR 00 0000000d
RW 0c 00000002
RR 00 00000001
T registers
RR 08 00000020
W 0a01
W 0a02
W 0a03
I 4
RR 04 00000003
C 0003
RR 10 00000000
T flush
W 0b01
W 0b02
I 3
RW 0c 00000001
F empty 1
RR 04 00000000
C 0000
W beef
R beef
F empty 1

// ==== tb/tb_fifo_sync_axil.sv ====
`timescale 1ns/10ps

module tb_fifo_sync_axil;

    import fifo_pkg::*;

    localparam int DEPTH   = 32;
    localparam int TIMEOUT = 200;

    // Signals that the waits and flag checks can poll
    localparam int SIG_EMPTY    = 0;
    localparam int SIG_FULL     = 1;
    localparam int SIG_WR_RDY   = 2;
    localparam int SIG_OFLOW    = 3;
    localparam int SIG_UFLOW    = 4;
    localparam int SIG_HAS_WORD = 5;
    localparam int SIG_AWREADY  = 6;
    localparam int SIG_BVALID   = 7;
    localparam int SIG_ARREADY  = 8;
    localparam int SIG_RVALID   = 9;

    logic       clk;
    logic       rst;
    logic       wr_rdy;
    logic       wr;
    data_t      wr_data;
    count_t     wr_count;
    logic       full;
    logic       oflow;
    logic       rd;
    logic       rd_ack;
    data_t      rd_data;
    count_t     rd_count;
    logic       empty;
    logic       uflow;
    logic       axil_awvalid;
    logic       axil_awready;
    axil_addr_t axil_awaddr;
    logic       axil_wvalid;
    logic       axil_wready;
    axil_data_t axil_wdata;
    logic [3:0] axil_wstrb;
    logic       axil_bvalid;
    logic       axil_bready;
    logic [1:0] axil_bresp;
    logic       axil_arvalid;
    logic       axil_arready;
    axil_addr_t axil_araddr;
    logic       axil_rvalid;
    logic       axil_rready;
    axil_data_t axil_rdata;
    logic [1:0] axil_rresp;

    // Reference model of the buffer contents
    data_t model[$];

    int    checks;
    int    errors;
    int    tests;
    int    failed_tests;
    int    test_checks;
    int    test_errors;
    bit    aborted;
    string test_name;

    fifo_sync_axil DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Result bookkeeping
    // ------------------------------
    task automatic tally(input bit ok);
        checks++;
        test_checks++;
        if (!ok) begin
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_data(input string sig, input data_t got, input data_t exp);
        tally(got === exp);
        if (got !== exp) $display("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp);
    endtask

    task automatic check_reg(input string sig, input axil_data_t got, input axil_data_t exp);
        tally(got === exp);
        if (got !== exp) $display("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp);
    endtask

    task automatic check_count(input string sig, input count_t got, input count_t exp);
        tally(got === exp);
        if (got !== exp) $display("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp);
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        tally(got === exp);
        if (got !== exp) $display("mismatch %s: got 0x%h, expected 0x%h", sig, got, exp);
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests++;
            if (test_errors == 0) begin
                $display("test %s: pass, %0d checks", test_name, test_checks);
            end else begin
                failed_tests++;
                $display("test %s: %0d errors in %0d checks", test_name, test_errors,
                         test_checks);
            end
        end
    endtask

    // ------------------------------
    // Cycle helpers
    // ------------------------------
    function automatic logic flag_value(input int code);
        case (code)
            SIG_EMPTY:    return empty;
            SIG_FULL:     return full;
            SIG_WR_RDY:   return wr_rdy;
            SIG_OFLOW:    return oflow;
            SIG_UFLOW:    return uflow;
            SIG_HAS_WORD: return !empty;
            SIG_AWREADY:  return axil_awready && axil_wready;
            SIG_BVALID:   return axil_bvalid;
            SIG_ARREADY:  return axil_arready;
            SIG_RVALID:   return axil_rvalid;
            default:      return 1'bx;
        endcase
    endfunction

    function automatic int flag_code(input string name);
        if (name == "empty") return SIG_EMPTY;
        if (name == "full") return SIG_FULL;
        if (name == "wr_rdy") return SIG_WR_RDY;
        if (name == "oflow") return SIG_OFLOW;
        if (name == "uflow") return SIG_UFLOW;
        return -1;
    endfunction

    // Inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) next_cycle();
    endtask

    // Polls at the falling edge, where outputs have settled
    task automatic wait_for(input int code, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (flag_value(code) !== 1'b1 && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (flag_value(code) !== 1'b1) begin
            report_error({"timed out waiting for ", what});
            aborted = 1'b1;
        end
    endtask

    // ------------------------------
    // FIFO port operations
    // ------------------------------
    task automatic write_word(input data_t w);
        wr      = 1'b1;
        wr_data = w;
        if (model.size() < DEPTH) model.push_back(w);
        next_cycle();
        wr = 1'b0;
    endtask

    task automatic read_word(input data_t exp);
        if (model.size() == 0) begin
            report_error("trace reads a word that the model does not hold");
        end else begin
            if (model[0] !== exp) report_error("trace word differs from the model head");
            void'(model.pop_front());
        end
        wait_for(SIG_HAS_WORD, "empty to fall");
        if (aborted) return;
        check_data("rd_data", rd_data, exp);
        next_cycle();
        rd = 1'b1;
        @(negedge clk);
        check_flag("rd_ack", rd_ack, 1'b1);
        next_cycle();
        rd = 1'b0;
    endtask

    task automatic read_empty();
        if (model.size() != 0) begin
            report_error("trace reads a buffer that the model says holds words");
        end
        rd = 1'b1;
        @(negedge clk);
        check_flag("rd_ack", rd_ack, 1'b0);
        next_cycle();
        rd = 1'b0;
    endtask

    // ------------------------------
    // AXI4-Lite bus operations
    // ------------------------------
    task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
        axil_awvalid = 1'b1;
        axil_awaddr  = addr;
        axil_wvalid  = 1'b1;
        axil_wdata   = data;
        axil_wstrb   = 4'hf;
        axil_bready  = 1'b1;
        if (addr == REG_CONTROL && data[CTRL_FLUSH_BIT]) model.delete();
        wait_for(SIG_AWREADY, "awready and wready");
        if (aborted) return;
        next_cycle();
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        wait_for(SIG_BVALID, "bvalid");
        if (aborted) return;
        check_reg("axil_bresp", axil_data_t'(axil_bresp), axil_data_t'(AXIL_RESP_OKAY));
        next_cycle();
        axil_bready = 1'b0;
    endtask

    task automatic reg_read(input axil_addr_t addr, input axil_data_t exp);
        axil_arvalid = 1'b1;
        axil_araddr  = addr;
        axil_rready  = 1'b1;
        wait_for(SIG_ARREADY, "arready");
        if (aborted) return;
        next_cycle();
        axil_arvalid = 1'b0;
        wait_for(SIG_RVALID, "rvalid");
        if (aborted) return;
        check_reg($sformatf("axil_rdata at 0x%h", addr), axil_rdata, exp);
        check_reg("axil_rresp", axil_data_t'(axil_rresp), axil_data_t'(AXIL_RESP_OKAY));
        next_cycle();
        axil_rready = 1'b0;
        if (addr == REG_COUNT && exp != axil_data_t'(model.size())) begin
            report_error("trace fill level differs from the model");
        end
    endtask

    // ------------------------------
    // Trace player
    // ------------------------------
    task automatic reject_line(input string op);
        report_error({"trace line ", op, " has missing or malformed arguments"});
        aborted = 1'b1;
    endtask

    initial begin
        int              fd;
        int              code;
        int              n;
        int              b;
        string           op;
        string           name;
        logic [31:0]     a;
        logic [31:0]     v;
        logic [8*128-1:0] rest;

        rst          = 1'b1;
        wr           = 1'b0;
        wr_data      = '0;
        rd           = 1'b0;
        axil_awvalid = 1'b0;
        axil_awaddr  = '0;
        axil_wvalid  = 1'b0;
        axil_wdata   = '0;
        axil_wstrb   = '0;
        axil_bready  = 1'b0;
        axil_arvalid = 1'b0;
        axil_araddr  = '0;
        axil_rready  = 1'b0;
        test_name    = "";
        void'($urandom(63865));

        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        fd = $fopen("tb/fifo_trace.txt", "r");
        if (fd == 0) begin
            report_error("cannot open tb/fifo_trace.txt");
            aborted = 1'b1;
        end

        while (!aborted && $fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else if (op == "T") begin
                code = $fscanf(fd, "%s", name);
                if (code != 1) begin
                    reject_line(op);
                end else begin
                    close_test();
                    test_name   = name;
                    test_checks = 0;
                    test_errors = 0;
                    idle_gap();
                end
            end else if (op == "W") begin
                code = $fscanf(fd, "%h", v);
                if (code != 1) reject_line(op);
                else write_word(data_t'(v));
            end else if (op == "WS") begin
                code = $fscanf(fd, "%h %d", v, n);
                if (code != 2) reject_line(op);
                else for (int i = 0; i < n; i++) write_word(data_t'(v + i));
            end else if (op == "R") begin
                code = $fscanf(fd, "%h", v);
                if (code != 1) reject_line(op);
                else read_word(data_t'(v));
            end else if (op == "RS") begin
                code = $fscanf(fd, "%h %d", v, n);
                if (code != 2) reject_line(op);
                else for (int i = 0; i < n && !aborted; i++) read_word(data_t'(v + i));
            end else if (op == "U") begin
                read_empty();
            end else if (op == "RW") begin
                code = $fscanf(fd, "%h %h", a, v);
                if (code != 2) begin
                    reject_line(op);
                end else begin
                    idle_gap();
                    reg_write(axil_addr_t'(a), v);
                end
            end else if (op == "RR") begin
                code = $fscanf(fd, "%h %h", a, v);
                if (code != 2) begin
                    reject_line(op);
                end else begin
                    idle_gap();
                    reg_read(axil_addr_t'(a), v);
                end
            end else if (op == "F") begin
                code = $fscanf(fd, "%s %d", name, b);
                if (code != 2) begin
                    reject_line(op);
                end else if (flag_code(name) < 0) begin
                    report_error({"trace names an unknown flag ", name});
                    aborted = 1'b1;
                end else begin
                    @(negedge clk);
                    check_flag(name, flag_value(flag_code(name)), b != 0);
                    next_cycle();
                end
            end else if (op == "C") begin
                code = $fscanf(fd, "%h", v);
                if (code != 1) begin
                    reject_line(op);
                end else begin
                    @(negedge clk);
                    check_count("wr_count", wr_count, count_t'(v));
                    check_count("rd_count", rd_count, count_t'(v));
                    if (v != model.size()) report_error("trace count differs from the model");
                    next_cycle();
                end
            end else if (op == "I") begin
                code = $fscanf(fd, "%d", n);
                if (code != 1) reject_line(op);
                else repeat (n) next_cycle();
            end else begin
                report_error({"trace holds an unknown operation ", op});
                aborted = 1'b1;
            end
        end
        close_test();
        if (fd != 0) $fclose(fd);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_fifo_sync_axil
